/* secded_defines.svh */
`ifndef SECDED_DEFINES_SVH
`define SECDED_DEFINES_SVH

////////////////////
// Extended Hamming (72,64) geometry

// Payload width of one word
`define SECDED_DATA_BITS 64

// Full codeword, overall parity at index 0 plus Hamming positions 1..71
`define SECDED_CODE_BITS 72

// Hamming parity bits at positions 1, 2, 4 ... 64
`define SECDED_PARITY_BITS 7

// Width of a bit index, also the syndrome width
`define SECDED_POS_BITS 7

`endif

/* secded_pkg.sv */
`include "secded_defines.svh"

package secded_pkg;

	////////////////////
	// Word types

	// One payload word
	typedef logic [`SECDED_DATA_BITS-1:0] data_word_t;

	// Index 0 is overall parity, 1..71 are Hamming positions
	typedef logic [`SECDED_CODE_BITS-1:0] codeword_t;

	// XOR of indices of all set Hamming positions
	typedef logic [`SECDED_POS_BITS-1:0] syndrome_t;

	// Error position
	typedef logic [`SECDED_POS_BITS-1:0] bit_pos_t;

	////////////////////
	// Shared code helpers

	// Data lives at every Hamming position that is not a power of two
	function automatic logic is_data_pos(int unsigned pos);
		return (pos != 0) && ((pos & (pos - 1)) != 0);
	endfunction

	// Syndrome over positions 1..71, bit 0 is left out
	function automatic syndrome_t calc_syndrome(codeword_t cw);
		syndrome_t s;
		s = '0;
		for (int i = 1; i < `SECDED_CODE_BITS; i++) begin
			if (cw[i])
				s ^= syndrome_t'(i);
		end
		return s;
	endfunction

endpackage

/* secded_encoder.sv */
`include "secded_defines.svh"

module secded_encoder (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   data_valid,
	input  secded_pkg::data_word_t data,
	output logic                   code_valid,
	output secded_pkg::codeword_t  code
);

	import secded_pkg::*;

	// Data bits scattered to their positions, parity slots still zero
	codeword_t placed;

	// Syndrome of the data-only word
	syndrome_t parity;

	// Finished codeword before the register
	codeword_t encoded;

	////////////////////
	// Data placement

	always_comb begin
		int di;
		placed = '0;
		di = 0;
		// Ascending fill, data bit 0 at position 3
		for (int pos = 1; pos < `SECDED_CODE_BITS; pos++) begin
			if (is_data_pos(pos)) begin
				placed[pos] = data[di];
				di++;
			end
		end
	end

	////////////////////
	// Parity generation

	// Parity slots are zero here, so this is the XOR per index bit
	assign parity = calc_syndrome(placed);

	always_comb begin
		encoded = placed;
		// Writing the syndrome into slot 2^p cancels it, final syndrome is zero
		for (int p = 0; p < `SECDED_PARITY_BITS; p++)
			encoded[1 << p] = parity[p];
		// Overall parity makes the whole 72-bit word even
		encoded[0] = ^encoded[`SECDED_CODE_BITS-1:1];
	end

	////////////////////
	// Output register

	always_ff @(posedge clk) begin
		if (rst)
			code_valid <= 1'b0;
		else
			code_valid <= data_valid;
	end

	// Codeword only changes with a new word
	always_ff @(posedge clk) begin
		if (data_valid)
			code <= encoded;
	end

endmodule

/* fault_injector.sv */
`include "secded_defines.svh"

module fault_injector (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  code_valid,
	input  secded_pkg::codeword_t code,
	input  logic [1:0]            err_count,
	input  secded_pkg::bit_pos_t  err_pos0,
	input  secded_pkg::bit_pos_t  err_pos1,
	output logic                  corrupt_valid,
	output secded_pkg::codeword_t corrupt
);

	import secded_pkg::*;

	// One bit set for every codeword bit to invert
	codeword_t flip_mask;

	////////////////////
	// Flip mask

	always_comb begin
		flip_mask = '0;
		// Any nonzero count uses the first position
		if ((err_count != 2'd0) && (err_pos0 < `SECDED_CODE_BITS))
			flip_mask[err_pos0] = 1'b1;
		// Counts 2 and 3 add the second one
		// XOR so equal positions cancel out
		if ((err_count >= 2'd2) && (err_pos1 < `SECDED_CODE_BITS))
			flip_mask[err_pos1] = flip_mask[err_pos1] ^ 1'b1;
	end

	////////////////////
	// Output register

	always_ff @(posedge clk) begin
		if (rst)
			corrupt_valid <= 1'b0;
		else
			corrupt_valid <= code_valid;
	end

	always_ff @(posedge clk) begin
		if (code_valid)
			corrupt <= code ^ flip_mask;
	end

endmodule

/* secded_decoder.sv */
`include "secded_defines.svh"

module secded_decoder (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   corrupt_valid,
	input  secded_pkg::codeword_t  corrupt,
	output logic                   out_valid,
	output logic                   correctable_err,
	output logic                   uncorrectable_err,
	output secded_pkg::data_word_t out_data
);

	import secded_pkg::*;

	// Nonzero points at the flipped Hamming position
	syndrome_t syndrome;

	// High when an odd number of bits flipped
	logic parity_odd;

	// Codeword after the single-bit repair
	codeword_t fixed;

	// Payload pulled from the repaired word
	data_word_t extracted;

	// Word classification before the register
	logic single_err;
	logic double_err;

	////////////////////
	// Syndrome and overall parity

	assign syndrome = calc_syndrome(corrupt);

	// Includes bit 0, a clean word XORs to zero
	assign parity_odd = ^corrupt;

	////////////////////
	// Classify and correct

	always_comb begin
		fixed      = corrupt;
		single_err = 1'b0;
		double_err = 1'b0;
		if (parity_odd) begin
			// Odd parity, one flip unless the syndrome is off the end
			if (syndrome < `SECDED_CODE_BITS) begin
				// Syndrome 0 means bit 0, which carries no data anyway
				fixed[syndrome] = ~corrupt[syndrome];
				single_err      = 1'b1;
			end else begin
				// Three or more flips aliased past position 71
				double_err = 1'b1;
			end
		end else if (syndrome != '0) begin
			// Even parity with a syndrome, two flips
			double_err = 1'b1;
		end
	end

	////////////////////
	// Data extraction

	// Same ascending order the encoder filled in
	always_comb begin
		int di;
		extracted = '0;
		di = 0;
		for (int pos = 1; pos < `SECDED_CODE_BITS; pos++) begin
			if (is_data_pos(pos)) begin
				extracted[di] = fixed[pos];
				di++;
			end
		end
	end

	////////////////////
	// Output registers

	// Flags only ever set alongside a word
	always_ff @(posedge clk) begin
		if (rst) begin
			out_valid         <= 1'b0;
			correctable_err   <= 1'b0;
			uncorrectable_err <= 1'b0;
		end else begin
			out_valid         <= corrupt_valid;
			correctable_err   <= corrupt_valid & single_err;
			uncorrectable_err <= corrupt_valid & double_err;
		end
	end

	// On an uncorrectable word this is the raw extraction
	always_ff @(posedge clk) begin
		if (corrupt_valid)
			out_data <= extracted;
	end

endmodule

/* secded_link.sv */
module secded_link (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   data_valid,
	input  secded_pkg::data_word_t data,
	input  logic [1:0]             err_count,
	input  secded_pkg::bit_pos_t   err_pos0,
	input  secded_pkg::bit_pos_t   err_pos1,
	output logic                   out_valid,
	output secded_pkg::data_word_t out_data,
	output logic                   correctable_err,
	output logic                   uncorrectable_err
);

	import secded_pkg::*;

	// Encoder to injector
	logic      code_valid;
	codeword_t code;

	// Injector to decoder
	logic      corrupt_valid;
	codeword_t corrupt;

	////////////////////
	// Encode, cycle 1

	secded_encoder i_secded_encoder (
		.clk        (clk),
		.rst        (rst),
		.data_valid (data_valid),
		.data       (data),
		.code_valid (code_valid),
		.code       (code)
	);

	////////////////////
	// Inject, cycle 2
	// Error controls are sampled while code_valid is high

	fault_injector i_fault_injector (
		.clk           (clk),
		.rst           (rst),
		.code_valid    (code_valid),
		.code          (code),
		.err_count     (err_count),
		.err_pos0      (err_pos0),
		.err_pos1      (err_pos1),
		.corrupt_valid (corrupt_valid),
		.corrupt       (corrupt)
	);

	////////////////////
	// Decode, cycle 3

	secded_decoder i_secded_decoder (
		.clk               (clk),
		.rst               (rst),
		.corrupt_valid     (corrupt_valid),
		.corrupt           (corrupt),
		.out_valid         (out_valid),
		.correctable_err   (correctable_err),
		.uncorrectable_err (uncorrectable_err),
		.out_data          (out_data)
	);

endmodule

/* tb_clock_gen.sv */
module tb_clock_gen (
	output logic clk
);

	// Half of the 40-unit period
	localparam int half_period = 20;

	// Starts low so the first rising edge lands at 20
	initial begin
		clk = 1'b0;
		forever #half_period clk = ~clk;
	end

endmodule

/* secded_checker.sv */
module secded_checker (
	input logic clk,
	input logic rst,
	input logic data_valid,
	input logic out_valid,
	input logic correctable_err,
	input logic uncorrectable_err
);

	// Count of failed properties
	int fail_count = 0;

	// Clock edges seen, saturates once $past has enough history
	int ticks = 0;

	always @(posedge clk) begin
		if (ticks < 4)
			ticks <= ticks + 1;
	end

	////////////////////
	// Properties

	// One word is either correctable or uncorrectable, never both
	flags_exclusive: assert property (@(posedge clk) disable iff (rst)
		!(correctable_err && uncorrectable_err))
		else begin
			$error("correctable_err and uncorrectable_err high together");
			fail_count++;
		end

	// Three register stages, none of them in reset
	latency_three: assert property (@(posedge clk)
		(ticks >= 4 && !$past(rst, 1) && !$past(rst, 2) && !$past(rst, 3))
		|-> (out_valid == $past(data_valid, 3)))
		else begin
			$error("out_valid does not follow data_valid by 3 cycles");
			fail_count++;
		end

	// Reset clears every output flag on the next edge
	reset_quiet: assert property (@(posedge clk)
		rst |=> (!out_valid && !correctable_err && !uncorrectable_err))
		else begin
			$error("output flags high after a reset cycle");
			fail_count++;
		end

endmodule

bind secded_link secded_checker i_secded_checker (
	.clk               (clk),
	.rst               (rst),
	.data_valid        (data_valid),
	.out_valid         (out_valid),
	.correctable_err   (correctable_err),
	.uncorrectable_err (uncorrectable_err)
);

/* tb_secded_link.sv */
`include "secded_defines.svh"

module tb_secded_link;

	import secded_pkg::*;

	////////////////////
	// Run length

	localparam int reset_cycles = 5;
	localparam int words_per_test = 300;
	// Four random tests plus the single word after reset
	localparam int total_words = 4 * words_per_test + 1;
	localparam int timeout_cycles = reset_cycles + total_words * 2 + 50;

	logic       clk;
	logic       rst;
	logic       data_valid;
	data_word_t data;
	logic [1:0] err_count;
	bit_pos_t   err_pos0;
	bit_pos_t   err_pos1;
	logic       out_valid;
	data_word_t out_data;
	logic       correctable_err;
	logic       uncorrectable_err;

	// Model queues, one entry per word in flight
	data_word_t exp_data_q[$];
	logic       exp_corr_q[$];
	logic       exp_unc_q[$];

	// data_valid of the last three cycles, bit 2 oldest
	logic [2:0] valid_hist;

	// Error controls of last cycle's word, driven one cycle late
	logic [1:0] next_count;
	bit_pos_t   next_pos0;
	bit_pos_t   next_pos1;

	int test_errors;
	int total_errors;
	int tests_passed;
	int tests_failed;
	int cycle_count;
	int assert_fails;

	tb_clock_gen i_tb_clock_gen (.clk(clk));

	secded_link i_secded_link (
		.clk               (clk),
		.rst               (rst),
		.data_valid        (data_valid),
		.data              (data),
		.err_count         (err_count),
		.err_pos0          (err_pos0),
		.err_pos1          (err_pos1),
		.out_valid         (out_valid),
		.out_data          (out_data),
		.correctable_err   (correctable_err),
		.uncorrectable_err (uncorrectable_err)
	);

	////////////////////
	// Reference model

	// Payload bit at a Hamming position, -1 for bit 0 and parity slots
	function automatic int data_index(int pos);
		int pow_count;
		if ((pos <= 0) || ((pos & (pos - 1)) == 0))
			return -1;
		pow_count = 0;
		for (int p = 1; p <= pos; p = p * 2)
			pow_count++;
		return pos - pow_count - 1;
	endfunction

	// Distinct in-range flips decide the class
	function automatic void predict_word(data_word_t d, logic [1:0] cnt, bit_pos_t p0,
		bit_pos_t p1);
		int         flips[$];
		int         idx;
		data_word_t exp_d;
		if ((cnt != 2'd0) && (p0 < `SECDED_CODE_BITS))
			flips.push_back(p0);
		if ((cnt >= 2'd2) && (p1 < `SECDED_CODE_BITS)) begin
			// Same bit twice cancels
			if ((flips.size() == 1) && (flips[0] == p1))
				flips.delete();
			else
				flips.push_back(p1);
		end
		exp_d = d;
		// Double error leaves the raw payload with both flips in it
		if (flips.size() == 2) begin
			foreach (flips[i]) begin
				idx = data_index(flips[i]);
				if (idx >= 0)
					exp_d[idx] = ~exp_d[idx];
			end
		end
		exp_data_q.push_back(exp_d);
		exp_corr_q.push_back(flips.size() == 1);
		exp_unc_q.push_back(flips.size() == 2);
	endfunction

	////////////////////
	// Checks and stimulus

	function automatic void compare_value(string name, logic [63:0] exp, logic [63:0] act);
		assert (act === exp) else begin
			$display("FAIL %s expected %0h actual %0h", name, exp, act);
			test_errors++;
		end
	endfunction

	// Outputs settle after the rising edge, read here at the falling one
	task automatic check_outputs();
		compare_value("out_valid", valid_hist[2], out_valid);
		if (out_valid !== 1'b1) begin
			compare_value("error flags", 0, {correctable_err, uncorrectable_err});
		end else begin
			assert (exp_data_q.size() != 0) else begin
				$display("Word came out with no word outstanding");
				test_errors++;
			end
			if (exp_data_q.size() != 0) begin
				compare_value("out_data", exp_data_q.pop_front(), out_data);
				compare_value("correctable_err", exp_corr_q.pop_front(), correctable_err);
				compare_value("uncorrectable_err", exp_unc_q.pop_front(), uncorrectable_err);
			end
		end
	endtask

	task automatic run_cycle(logic dv, logic [1:0] cnt, bit_pos_t p0, bit_pos_t p1);
		data_word_t d;
		@(negedge clk);
		check_outputs();
		d = {$urandom, $urandom};
		data_valid = dv;
		data = d;
		err_count = next_count;
		err_pos0 = next_pos0;
		err_pos1 = next_pos1;
		next_count = dv ? cnt : 2'd0;
		next_pos0 = p0;
		next_pos1 = p1;
		valid_hist = {valid_hist[1:0], dv};
		if (dv)
			predict_word(d, cnt, p0, p1);
	endtask

	// Idle until every word has come out
	task automatic drain_pipeline();
		while ((exp_data_q.size() != 0) || (valid_hist != 3'b000))
			run_cycle(1'b0, 2'd0, '0, '0);
	endtask

	task automatic report_test(string name);
		total_errors += test_errors;
		if (test_errors == 0) begin
			tests_passed++;
			$display("Test %s: passed", name);
		end else begin
			tests_failed++;
			$display("Test %s: failed with %0d errors", name, test_errors);
		end
	endtask

	// Mode 0 clean, 1 single, 2 double, 3 mixed with gaps
	task automatic run_test(string name, int mode);
		logic [1:0] cnt;
		bit_pos_t   p0;
		bit_pos_t   p1;
		test_errors = 0;
		for (int w = 0; w < words_per_test; w++) begin
			cnt = mode[1:0];
			p0 = bit_pos_t'($urandom % `SECDED_CODE_BITS);
			// Second position skips the first one
			p1 = bit_pos_t'($urandom % (`SECDED_CODE_BITS - 1));
			if (p1 >= p0)
				p1 = p1 + 1'b1;
			if (mode == 3) begin
				cnt = 2'($urandom % 4);
				p0 = bit_pos_t'($urandom % 128);
				p1 = bit_pos_t'($urandom % 128);
				while (($urandom % 4) == 0)
					run_cycle(1'b0, 2'd0, '0, '0);
			end
			run_cycle(1'b1, cnt, p0, p1);
		end
		drain_pipeline();
		report_test(name);
	endtask

	////////////////////
	// Main sequence

	initial begin
		void'($urandom(32'h1ee9));
		rst = 1'b1;
		// Words offered during reset must never come out
		data_valid = 1'b1;
		data = '0;
		err_count = 2'd0;
		err_pos0 = '0;
		err_pos1 = '0;
		next_count = 2'd0;
		next_pos0 = '0;
		next_pos1 = '0;
		valid_hist = 3'b000;
		test_errors = 0;
		total_errors = 0;
		tests_passed = 0;
		tests_failed = 0;
		repeat (reset_cycles) begin
			@(negedge clk);
			compare_value("out_valid", 0, out_valid);
			compare_value("error flags", 0, {correctable_err, uncorrectable_err});
			data = {$urandom, $urandom};
		end
		rst = 1'b0;
		data_valid = 1'b0;
		repeat (4)
			run_cycle(1'b0, 2'd0, '0, '0);
		run_cycle(1'b1, 2'd0, '0, '0);
		drain_pipeline();
		report_test("reset quiet");
		run_test("clean words", 0);
		run_test("single errors", 1);
		run_test("double errors", 2);
		run_test("mixed traffic", 3);
		assert_fails = i_secded_link.i_secded_checker.fail_count;
		$display("Tests passed %0d, failed %0d, errors %0d, assertion failures %0d",
			tests_passed, tests_failed, total_errors, assert_fails);
		if ((tests_failed == 0) && (assert_fails == 0))
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

	// Run limit in clock cycles
	initial begin
		cycle_count = 0;
		while (cycle_count < timeout_cycles) begin
			@(posedge clk);
			cycle_count++;
		end
		$display("Timeout after %0d cycles with words still expected", cycle_count);
		$display("=== FAIL ===");
		$finish;
	end

endmodule

/* verilog.f */
+incdir+.
secded_pkg.sv
secded_encoder.sv
fault_injector.sv
secded_decoder.sv
secded_link.sv
tb_clock_gen.sv
secded_checker.sv
tb_secded_link.sv
